// ==== common/cnn_layer_pkg.sv ====
package cnn_layer_pkg;

   // --------------------
   // layer setup
   // --------------------

   // sampled together with the start pulse
   typedef struct packed {
      // feature height and width before pooling
      logic [7:0] out_size;
      // channel count, a whole number of lane groups
      logic [7:0] out_channel;
   } layer_cfg_t;

   // pooling either runs or waits for the next start
   typedef enum logic {
      LAYER_IDLE,
      LAYER_POOLING
   } layer_state_e;

   // --------------------
   // ping-pong feature memory
   // --------------------

   // first word of the upper half, lower half starts at 0
   localparam int HALF_BASE = 1024;

   // layer counter width, its lsb picks the half
   localparam int LAYER_W = 4;

endpackage

// ==== common/cnn_data_pkg.sv ====
package cnn_data_pkg;

   // --------------------
   // default datapath size
   // --------------------

   // bits per signed lane
   localparam int DATA_W_DEF = 16;

   // lanes per pixel vector, lane 0 in the low bits
   localparam int POOL_PAR_DEF = 8;

   // feature words, two halves of HALF_BASE each
   localparam int MEM_DEPTH_DEF = 2048;

   // --------------------
   // pooled result fields
   // --------------------

   // row, column or group index
   typedef logic [7:0] pos_t;

   // result word is valid, pooled row, pooled column, group, then the vector
   // modules build the struct themselves since the vector width is a parameter
   localparam int POS_FIELDS = 3;

endpackage

// ==== logic/layer_control.sv ====
`timescale 1ns/100ps

module layer_control
   import cnn_layer_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               start,
   input  layer_cfg_t         cfg,
   input  logic               pix_valid,
   input  logic               window_last,
   output logic               pix_take,
   output layer_cfg_t         active_cfg,
   output logic               upper_half,
   output logic               busy,
   output logic               layer_done,
   output logic [LAYER_W-1:0] layer_index
);

   layer_state_e state;

   // window_last delayed once, lines done up with the last memory write
   logic last_q;

   assign busy = (state == LAYER_POOLING);

   // stray pixels outside a layer never reach the pooling counters
   assign pix_take = pix_valid & busy;

   // even layers write the upper half, odd layers the lower one
   assign upper_half = ~layer_index[0];

   // --------------------
   // layer sequencing
   // --------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= LAYER_IDLE;
         active_cfg  <= '0;
         layer_index <= '0;
         last_q      <= 1'b0;
         layer_done  <= 1'b0;
      end else begin
         last_q     <= window_last;
         // final result registered, then written, then done
         layer_done <= last_q;
         if (state == LAYER_IDLE) begin
            // a start while busy falls through here unseen
            if (start) begin
               state      <= LAYER_POOLING;
               active_cfg <= cfg;
            end
         end else if (last_q) begin
            state       <= LAYER_IDLE;
            layer_index <= layer_index + 1'b1;
         end
      end
   end

endmodule

// ==== pool/pool_line_store.sv ====
`timescale 1ns/100ps

module pool_line_store
   import cnn_data_pkg::*;
#(
   parameter int DATA_W   = DATA_W_DEF,
   parameter int POOL_PAR = POOL_PAR_DEF,
   localparam int VEC_W   = DATA_W * POOL_PAR
) (
   input  logic             clk,
   input  logic             pair_we,
   input  pos_t             pair_group,
   input  logic [VEC_W-1:0] pair_data,
   input  logic             row_we,
   input  logic [6:0]       row_slot,
   input  logic [VEC_W-1:0] row_data,
   input  pos_t             pair_rd_group,
   input  logic [6:0]       row_rd_slot,
   output logic [VEC_W-1:0] pair_q,
   output logic [VEC_W-1:0] row_q
);

   // one entry per lane group of an 8-bit channel count
   localparam int PAIR_SLOTS = 256 / POOL_PAR;
   localparam int PG_W       = $clog2(PAIR_SLOTS);

   // half a row of pooled columns times the groups
   localparam int ROW_SLOTS  = 128;

   // --------------------
   // even-column hold
   // --------------------

   // left pixel of each horizontal pair, waits for the odd column
   logic [VEC_W-1:0] pair_mem [PAIR_SLOTS];

   always_ff @(posedge clk) begin
      if (pair_we) begin
         pair_mem[pair_group[PG_W-1:0]] <= pair_data;
      end
   end

   // combinational read so the odd column compares in its own cycle
   assign pair_q = pair_mem[pair_rd_group[PG_W-1:0]];

   // --------------------
   // pooled row hold
   // --------------------

   // horizontal maxima of the even row, used by the odd row below
   logic [VEC_W-1:0] row_mem [ROW_SLOTS];

   always_ff @(posedge clk) begin
      if (row_we) begin
         row_mem[row_slot] <= row_data;
      end
   end

   // also combinational, the window completes on its last pixel
   assign row_q = row_mem[row_rd_slot];

endmodule

// ==== pool/pool_unit.sv ====
`timescale 1ns/100ps

module pool_unit
   import cnn_layer_pkg::*, cnn_data_pkg::*;
#(
   parameter int DATA_W   = DATA_W_DEF,
   parameter int POOL_PAR = POOL_PAR_DEF,
   localparam int VEC_W   = DATA_W * POOL_PAR,
   localparam int RES_W   = 1 + POS_FIELDS * $bits(pos_t) + VEC_W
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             pix_take,
   input  logic [VEC_W-1:0] pix,
   input  layer_cfg_t       active_cfg,
   output logic [RES_W-1:0] result,
   output logic             window_last
);

   typedef struct packed {
      logic             valid;
      pos_t             row;
      pos_t             col;
      pos_t             group;
      logic [VEC_W-1:0] data;
   } pool_result_t;

   pool_result_t     res_q;
   pos_t             row;
   pos_t             col;
   pos_t             group;
   pos_t             groups;
   logic             last_group;
   logic             last_col;
   logic             last_row;
   logic             win_done;
   logic [6:0]       slot;
   logic [VEC_W-1:0] pair_q;
   logic [VEC_W-1:0] row_q;
   logic [VEC_W-1:0] hmax;
   logic [VEC_W-1:0] vmax;

   // lane-wise signed max of two vectors
   function automatic logic [VEC_W-1:0] vec_max(input logic [VEC_W-1:0] a,
                                                input logic [VEC_W-1:0] b);
      logic signed [DATA_W-1:0] la;
      logic signed [DATA_W-1:0] lb;
      logic [VEC_W-1:0]         m;
      m = '0;
      for (int i = 0; i < POOL_PAR; i++) begin
         la = a[i*DATA_W +: DATA_W];
         lb = b[i*DATA_W +: DATA_W];
         m[i*DATA_W +: DATA_W] = (la > lb) ? la : lb;
      end
      return m;
   endfunction

   assign groups     = pos_t'(active_cfg.out_channel / POOL_PAR);
   assign last_group = (group == groups - 8'd1);
   assign last_col   = (col == active_cfg.out_size - 8'd1);
   assign last_row   = (row == active_cfg.out_size - 8'd1);

   // row store slot, one per pooled column and group
   assign slot = 7'((col >> 1) * groups + group);

   // --------------------
   // 1x2 then 2x1 stage
   // --------------------
   assign hmax = vec_max(pix, pair_q);
   assign vmax = vec_max(hmax, row_q);

   // bottom-right pixel of a 2x2 window
   assign win_done = pix_take & col[0] & row[0];

   pool_line_store #(
      .DATA_W   (DATA_W),
      .POOL_PAR (POOL_PAR)
   ) u_line_store (
      .clk           (clk),
      .pair_we       (pix_take & ~col[0]),
      .pair_group    (group),
      .pair_data     (pix),
      .row_we        (pix_take & col[0] & ~row[0]),
      .row_slot      (slot),
      .row_data      (hmax),
      .pair_rd_group (group),
      .row_rd_slot   (slot),
      .pair_q        (pair_q),
      .row_q         (row_q)
   );

   // raster position, group fastest, then column, then row
   always_ff @(posedge clk) begin
      if (reset) begin
         row   <= '0;
         col   <= '0;
         group <= '0;
      end else if (pix_take) begin
         if (last_group) begin
            group <= '0;
            if (last_col) begin
               col <= '0;
               // wraps to zero for the next layer
               row <= last_row ? '0 : row + 8'd1;
            end else begin
               col <= col + 8'd1;
            end
         end else begin
            group <= group + 8'd1;
         end
      end
   end

   // result register, payload only moves with a finished window
   always_ff @(posedge clk) begin
      if (reset) begin
         res_q.valid <= 1'b0;
         window_last <= 1'b0;
      end else begin
         res_q.valid <= win_done;
         window_last <= win_done & last_group & last_col & last_row;
      end
      if (win_done) begin
         res_q.row   <= row >> 1;
         res_q.col   <= col >> 1;
         res_q.group <= group;
         res_q.data  <= vmax;
      end
   end

   assign result = res_q;

endmodule

// ==== logic/feature_addr_gen.sv ====
`timescale 1ns/100ps

module feature_addr_gen
   import cnn_layer_pkg::*, cnn_data_pkg::*;
#(
   parameter int DATA_W    = DATA_W_DEF,
   parameter int POOL_PAR  = POOL_PAR_DEF,
   parameter int MEM_DEPTH = MEM_DEPTH_DEF,
   localparam int VEC_W    = DATA_W * POOL_PAR,
   localparam int AW       = $clog2(MEM_DEPTH),
   localparam int RES_W    = 1 + POS_FIELDS * $bits(pos_t) + VEC_W
) (
   input  logic             clk,
   input  logic             reset,
   input  logic [RES_W-1:0] result,
   input  layer_cfg_t       active_cfg,
   input  logic             upper_half,
   output logic             wr_en,
   output logic [AW-1:0]    wr_addr,
   output logic [VEC_W-1:0] wr_data
);

   typedef struct packed {
      logic             valid;
      pos_t             row;
      pos_t             col;
      pos_t             group;
      logic [VEC_W-1:0] data;
   } pool_result_t;

   pool_result_t  res;
   logic [AW-1:0] groups_w;
   logic [AW-1:0] row_words;
   logic [AW-1:0] base;
   logic [AW-1:0] addr_next;

   assign res = result;

   // words per pooled position and per pooled row
   assign groups_w  = AW'(active_cfg.out_channel / POOL_PAR);
   assign row_words = AW'(active_cfg.out_size >> 1) * groups_w;

   // ping-pong half
   assign base = upper_half ? AW'(HALF_BASE) : '0;

   assign addr_next = base + AW'(res.row) * row_words + AW'(res.col) * groups_w
                      + AW'(res.group);

   // write port register, one cycle behind the pooled result
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_en <= 1'b0;
      end else begin
         wr_en <= res.valid;
      end
      if (res.valid) begin
         wr_addr <= addr_next;
         wr_data <= res.data;
      end
   end

endmodule

// ==== logic/feature_mem.sv ====
`timescale 1ns/100ps

module feature_mem
   import cnn_data_pkg::*;
#(
   parameter int DATA_W    = DATA_W_DEF,
   parameter int POOL_PAR  = POOL_PAR_DEF,
   parameter int MEM_DEPTH = MEM_DEPTH_DEF,
   localparam int VEC_W    = DATA_W * POOL_PAR,
   localparam int AW       = $clog2(MEM_DEPTH)
) (
   input  logic             clk,
   input  logic             wr_en,
   input  logic [AW-1:0]    wr_addr,
   input  logic [VEC_W-1:0] wr_data,
   input  logic [AW-1:0]    rd_addr,
   output logic [VEC_W-1:0] rd_data
);

   // one pooled vector per word, both halves in one array
   logic [VEC_W-1:0] mem [MEM_DEPTH];

   // --------------------
   // pool write port
   // --------------------
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // --------------------
   // read-back port
   // --------------------

   // registered, data follows the address by one cycle
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// ==== logic/cnn_pool_top.sv ====
`timescale 1ns/100ps

module cnn_pool_top
   import cnn_layer_pkg::*, cnn_data_pkg::*;
#(
   parameter int DATA_W    = DATA_W_DEF,
   parameter int POOL_PAR  = POOL_PAR_DEF,
   parameter int MEM_DEPTH = MEM_DEPTH_DEF,
   localparam int VEC_W    = DATA_W * POOL_PAR,
   localparam int AW       = $clog2(MEM_DEPTH),
   localparam int RES_W    = 1 + POS_FIELDS * $bits(pos_t) + VEC_W
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               start,
   input  layer_cfg_t         cfg,
   input  logic               pix_valid,
   input  logic [VEC_W-1:0]   pix,
   input  logic [AW-1:0]      rd_addr,
   output logic [VEC_W-1:0]   rd_data,
   output logic               busy,
   output logic               layer_done,
   output logic [LAYER_W-1:0] layer_index
);

   layer_cfg_t       active_cfg;
   logic             pix_take;
   logic             upper_half;
   logic             window_last;
   logic [RES_W-1:0] pool_res;
   logic             wr_en;
   logic [AW-1:0]    wr_addr;
   logic [VEC_W-1:0] wr_data;

   // layer start, pixel gating and ping-pong select
   layer_control u_layer_control (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .cfg         (cfg),
      .pix_valid   (pix_valid),
      .window_last (window_last),
      .pix_take    (pix_take),
      .active_cfg  (active_cfg),
      .upper_half  (upper_half),
      .busy        (busy),
      .layer_done  (layer_done),
      .layer_index (layer_index)
   );

   // 2x2 max pool over each lane group
   pool_unit #(
      .DATA_W   (DATA_W),
      .POOL_PAR (POOL_PAR)
   ) u_pool_unit (
      .clk         (clk),
      .reset       (reset),
      .pix_take    (pix_take),
      .pix         (pix),
      .active_cfg  (active_cfg),
      .result      (pool_res),
      .window_last (window_last)
   );

   feature_addr_gen #(
      .DATA_W    (DATA_W),
      .POOL_PAR  (POOL_PAR),
      .MEM_DEPTH (MEM_DEPTH)
   ) u_addr_gen (
      .clk        (clk),
      .reset      (reset),
      .result     (pool_res),
      .active_cfg (active_cfg),
      .upper_half (upper_half),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data)
   );

   feature_mem #(
      .DATA_W    (DATA_W),
      .POOL_PAR  (POOL_PAR),
      .MEM_DEPTH (MEM_DEPTH)
   ) u_feature_mem (
      .clk     (clk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
   parameter int HALF_PERIOD = 2
) (
   output logic clk,
   output logic reset
);

   // free running, 4 ns period
   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // reset held over the first two rising edges, released just after
   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      #1 reset = 1'b0;
   end

endmodule

// ==== tests/cnn_pool_asserts.sv ====
`timescale 1ns/100ps

module cnn_pool_asserts
   import cnn_layer_pkg::*;
(
   input logic               clk,
   input logic               reset,
   input logic               start,
   input logic               pix_take,
   input logic               window_last,
   input logic               busy,
   input logic               layer_done,
   input logic [LAYER_W-1:0] layer_index
);

   // failed assertions so far for the testbench summary
   int fail_count = 0;

   // --------------------
   // reset state
   // --------------------
   a_reset_state: assert property (@(posedge clk)
      reset |=> (!busy && !layer_done && layer_index == '0))
      else begin
         fail_count++;
         $error("busy, layer_done or layer_index not cleared by reset");
      end

   // --------------------
   // end of layer
   // --------------------

   // final window result, then memory write, then done
   a_done_follows_last: assert property (@(posedge clk) disable iff (reset)
      window_last |-> ##2 layer_done)
      else begin
         fail_count++;
         $error("layer_done missing two cycles after the last window");
      end

   // done only three cycles after the final accepted pixel
   a_done_cause: assert property (@(posedge clk) disable iff (reset)
      layer_done |-> ($past(window_last, 2) && $past(pix_take, 3)))
      else begin
         fail_count++;
         $error("layer_done not three cycles after the final pixel");
      end

   a_done_single: assert property (@(posedge clk) disable iff (reset)
      layer_done |=> !layer_done)
      else begin
         fail_count++;
         $error("layer_done held longer than one cycle");
      end

   // busy falls in the done cycle
   a_busy_drop: assert property (@(posedge clk) disable iff (reset)
      layer_done |-> (!busy && $past(busy)))
      else begin
         fail_count++;
         $error("busy did not fall together with layer_done");
      end

   a_index_step: assert property (@(posedge clk) disable iff (reset)
      layer_done |-> (layer_index == LAYER_W'($past(layer_index) + 1'b1)))
      else begin
         fail_count++;
         $error("layer_index did not step by one at layer_done");
      end

   // a layer begins only on a start pulse
   a_busy_start: assert property (@(posedge clk) disable iff (reset)
      $rose(busy) |-> $past(start))
      else begin
         fail_count++;
         $error("busy rose without a start pulse");
      end

endmodule

bind cnn_pool_top cnn_pool_asserts u_asserts (
   .clk         (clk),
   .reset       (reset),
   .start       (start),
   .pix_take    (pix_take),
   .window_last (window_last),
   .busy        (busy),
   .layer_done  (layer_done),
   .layer_index (layer_index)
);

// ==== tests/cnn_pool_tb.sv ====
`timescale 1ns/100ps

module cnn_pool_tb
   import cnn_layer_pkg::*, cnn_data_pkg::*;
();

   localparam int DATA_W      = DATA_W_DEF;
   localparam int POOL_PAR    = POOL_PAR_DEF;
   localparam int MEM_DEPTH   = MEM_DEPTH_DEF;
   localparam int VEC_W       = DATA_W * POOL_PAR;
   localparam int AW          = $clog2(MEM_DEPTH);
   // about 700 pixel cycles with gaps plus read-back, with a wide margin
   localparam int CYCLE_LIMIT = 6000;

   logic               clk;
   logic               reset;
   logic               start;
   layer_cfg_t         cfg;
   logic               pix_valid;
   logic [VEC_W-1:0]   pix;
   logic [AW-1:0]      rd_addr;
   logic [VEC_W-1:0]   rd_data;
   logic               busy;
   logic               layer_done;
   logic [LAYER_W-1:0] layer_index;

   // reference image of the feature memory
   logic [VEC_W-1:0]   exp_mem [MEM_DEPTH];
   bit                 exp_set [MEM_DEPTH];
   // pixels of the current layer in raster order
   logic [VEC_W-1:0]   pix_img [256];
   int                 read_errors = 0;
   int                 layers_run = 0;
   int                 cycles = 0;
   int                 seed_sink;

   tb_clock u_clock (
      .clk   (clk),
      .reset (reset)
   );

   cnn_pool_top #(
      .DATA_W    (DATA_W),
      .POOL_PAR  (POOL_PAR),
      .MEM_DEPTH (MEM_DEPTH)
   ) DUT (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .cfg         (cfg),
      .pix_valid   (pix_valid),
      .pix         (pix),
      .rd_addr     (rd_addr),
      .rd_data     (rd_data),
      .busy        (busy),
      .layer_done  (layer_done),
      .layer_index (layer_index)
   );

   // --------------------
   // reference model
   // --------------------

   function automatic logic [VEC_W-1:0] random_vector();
      logic [VEC_W-1:0] v;
      for (int i = 0; i < POOL_PAR; i++) begin
         v[i*DATA_W +: DATA_W] = DATA_W'($urandom);
      end
      return v;
   endfunction

   // largest signed lane value over the four pixels of a window
   function automatic logic [VEC_W-1:0] window_max(input logic [VEC_W-1:0] p0,
                                                   input logic [VEC_W-1:0] p1,
                                                   input logic [VEC_W-1:0] p2,
                                                   input logic [VEC_W-1:0] p3);
      logic signed [DATA_W-1:0] cand [4];
      logic signed [DATA_W-1:0] best;
      logic [VEC_W-1:0]         m;
      for (int i = 0; i < POOL_PAR; i++) begin
         cand[0] = p0[i*DATA_W +: DATA_W];
         cand[1] = p1[i*DATA_W +: DATA_W];
         cand[2] = p2[i*DATA_W +: DATA_W];
         cand[3] = p3[i*DATA_W +: DATA_W];
         best = cand[0];
         for (int k = 1; k < 4; k++) begin
            if (cand[k] > best) begin
               best = cand[k];
            end
         end
         m[i*DATA_W +: DATA_W] = best;
      end
      return m;
   endfunction

   function automatic logic [VEC_W-1:0] pixel_at(input int r, input int c, input int g,
                                                 input int size, input int groups);
      return pix_img[(r * size + c) * groups + g];
   endfunction

   // one word per pooled position and group, row-major, in the layer's half
   task automatic expect_layer(input int size, input int groups, input bit upper);
      int half;
      int base;
      int addr;
      half = size / 2;
      base = upper ? HALF_BASE : 0;
      for (int pr = 0; pr < half; pr++) begin
         for (int pc = 0; pc < half; pc++) begin
            for (int g = 0; g < groups; g++) begin
               addr = base + (pr * half + pc) * groups + g;
               exp_mem[addr] = window_max(pixel_at(2*pr, 2*pc, g, size, groups),
                                          pixel_at(2*pr, 2*pc+1, g, size, groups),
                                          pixel_at(2*pr+1, 2*pc, g, size, groups),
                                          pixel_at(2*pr+1, 2*pc+1, g, size, groups));
               exp_set[addr] = 1'b1;
            end
         end
      end
   endtask

   // --------------------
   // stimulus
   // --------------------

   // pixels while no layer runs, must be dropped
   task automatic send_idle_pixels(input int count);
      for (int i = 0; i < count; i++) begin
         pix_valid = 1'b1;
         pix = random_vector();
         @(posedge clk);
         #1;
         pix_valid = 1'b0;
         @(posedge clk);
         #1;
      end
   endtask

   // one layer, optionally with a second start halfway through
   task automatic run_layer(input int size, input int chans, input int max_gap,
                            input bit stray_start);
      int groups;
      int total;
      int gap;
      bit upper;
      groups = chans / POOL_PAR;
      total = size * size * groups;
      upper = (layers_run % 2 == 0);
      cfg = '{out_size: 8'(size), out_channel: 8'(chans)};
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      for (int n = 0; n < total; n++) begin
         pix_img[n] = random_vector();
         pix = pix_img[n];
         pix_valid = 1'b1;
         if (stray_start && n == total / 2) begin
            cfg = '{out_size: 8'd8, out_channel: 8'd8};
            start = 1'b1;
         end
         @(posedge clk);
         #1;
         start = 1'b0;
         // no gap after the last pixel so the done pulse is not missed
         gap = (n < total - 1) ? $urandom_range(max_gap, 0) : 0;
         if (gap > 0) begin
            pix_valid = 1'b0;
            repeat (gap) begin
               @(posedge clk);
               #1;
            end
         end
      end
      pix_valid = 1'b0;
      if (stray_start) begin
         assert (DUT.active_cfg.out_size == 8'(size) &&
                 DUT.active_cfg.out_channel == 8'(chans))
         else begin
            read_errors++;
            $display("ERROR %0t: active configuration changed by a start mid-layer", $time);
         end
      end
      // the global cycle limit bounds this wait
      do begin
         @(posedge clk);
         #1;
      end while (!layer_done);
      expect_layer(size, groups, upper);
      layers_run++;
   endtask

   // registered read, data one cycle after the address
   task automatic read_back(input int lo, input int hi);
      for (int a = lo; a <= hi; a++) begin
         if (exp_set[a]) begin
            rd_addr = AW'(a);
            @(posedge clk);
            #1;
            assert (rd_data === exp_mem[a])
            else begin
               read_errors++;
               $display("ERROR %0t: word %0d read %h, expected %h",
                        $time, a, rd_data, exp_mem[a]);
            end
         end
      end
   endtask

   // --------------------
   // summary and end of run
   // --------------------
   task automatic finish_run(input bit timed_out);
      int proto;
      proto = DUT.u_asserts.fail_count;
      $display("errors: read-back %0d, protocol %0d, timeout %0d",
               read_errors, proto, timed_out);
      if (read_errors == 0 && proto == 0 && !timed_out) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
   end

   initial begin
      wait (cycles >= CYCLE_LIMIT);
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      finish_run(1'b1);
   end

   initial begin
      seed_sink = $urandom(53);
      start = 1'b0;
      cfg = '0;
      pix_valid = 1'b0;
      pix = '0;
      rd_addr = '0;
      wait (reset == 1'b0);
      @(posedge clk);
      #1;
      send_idle_pixels(3);
      // layer 0, one group, back to back, upper half
      run_layer(4, 8, 0, 1'b0);
      read_back(HALF_BASE, HALF_BASE + 3);
      // layer 1, two groups with gaps, lower half
      run_layer(8, 16, 3, 1'b0);
      read_back(0, 31);
      read_back(HALF_BASE, HALF_BASE + 3);
      // layer 2 after stray pixels, with a start mid-layer
      send_idle_pixels(5);
      run_layer(4, 16, 1, 1'b1);
      read_back(0, 31);
      read_back(HALF_BASE, HALF_BASE + 7);
      repeat (4) @(posedge clk);
      finish_run(1'b0);
   end

endmodule

// ==== list.f ====
common/cnn_layer_pkg.sv
common/cnn_data_pkg.sv
logic/layer_control.sv
pool/pool_line_store.sv
pool/pool_unit.sv
logic/feature_addr_gen.sv
logic/feature_mem.sv
logic/cnn_pool_top.sv
tests/tb_clock.sv
tests/cnn_pool_asserts.sv
tests/cnn_pool_tb.sv
